/* icmp_pkg.sv */
// ------------------------------
// shared types and protocol constants for the ICMP echo-reply transmitter
// referenced by scoped name from every RTL file and from the testbench
// ------------------------------
`default_nettype none

package icmp_pkg;

    typedef logic [47:0] mac_addr_t;
    typedef logic [31:0] ip_addr_t;

    // one frame request, latched by the sequencer on the start edge
    typedef struct packed {
        mac_addr_t   des_mac;
        ip_addr_t    des_ip;
        logic [15:0] icmp_id;
        logic [15:0] icmp_seq;
        logic [15:0] byte_num;  // payload bytes, never zero
        logic [31:0] data_sum;  // sum of payload halfwords
    } frame_req_t;

    typedef struct packed {
        logic       en;
        logic [7:0] txd;
    } gmii_tx_t;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_CHECKSUM,
        ST_PREAMBLE,
        ST_ETH_HEAD,
        ST_IP_HEAD,
        ST_DATA,
        ST_FCS
    } tx_state_e;

    typedef enum logic [7:0] {
        ICMP_ECHO_REPLY   = 8'd0,
        ICMP_ECHO_REQUEST = 8'd8
    } icmp_type_e;

    // ------------------------------
    // header field values
    // ------------------------------
    localparam logic [15:0] ETH_TYPE_IPV4   = 16'h0800;
    localparam logic [7:0]  IP_VER_IHL      = 8'h45;   // v4, 5 words
    localparam logic [15:0] IP_FLAGS_DF     = 16'h4000;
    localparam logic [7:0]  IP_TTL          = 8'h80;
    localparam logic [7:0]  IP_PROTO_ICMP   = 8'd1;
    localparam int          IP_ICMP_HDR_LEN = 28;      // 20 ip + 8 icmp
    localparam int          MIN_PAYLOAD     = 18;      // 46 - 28
    localparam logic [7:0]  PREAMBLE_BYTE   = 8'h55;
    localparam logic [7:0]  SFD_BYTE        = 8'hd5;
    localparam logic [31:0] CRC_POLY_REFL   = 32'hedb88320;

endpackage

`default_nettype wire

/* inet_checksum.sv */
// ------------------------------
// internet checksum over N_WORDS halfwords plus a 32-bit addend
// pulse calc_start with the operands, result follows 3 cycles later
// ------------------------------
`default_nettype none

module inet_checksum #(
    parameter int N_WORDS = 10
) (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire                      calc_start,
    input  wire  [N_WORDS-1:0][15:0] words,
    input  wire  [31:0]              extra,
    output logic [15:0]              csum,
    output logic                     csum_valid
);

    logic [31:0] sum_c;     // combinational total of all operands
    logic [31:0] acc;
    logic [16:0] fold1;     // first fold, may carry once more
    logic [15:0] fold2;
    logic        acc_v;
    logic        fold_v;

    always_comb begin
        sum_c = extra;
        for (int i = 0; i < N_WORDS; i++) begin
            sum_c = sum_c + 32'(words[i]);
        end
    end

    assign fold2 = fold1[15:0] + 16'(fold1[16]);  // cannot overflow again

    // stage valids
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc_v      <= 1'b0;
            fold_v     <= 1'b0;
            csum_valid <= 1'b0;
        end else begin
            acc_v      <= calc_start;
            fold_v     <= acc_v;
            csum_valid <= fold_v;
        end
    end

    // datapath: sum, fold, fold and invert
    always_ff @(posedge clk) begin
        if (calc_start)
            acc <= sum_c;
        if (acc_v)
            fold1 <= acc[31:16] + acc[15:0];
        if (fold_v)
            csum <= ~fold2;
    end

    // the pipeline holds one operation at a time
    a_no_overlap: assert property (@(posedge clk) disable iff (!rst_n)
        calc_start |=> !calc_start [*2]);

endmodule

`default_nettype wire

/* eth_fcs.sv */
// ------------------------------
// ethernet FCS, reflected CRC-32 one byte per clock
// clear at frame start, enable with each byte after the SFD
// ------------------------------
`default_nettype none

module eth_fcs (
    input  wire         clk,
    input  wire         rst_n,
    input  wire         fcs_clear,
    input  wire         fcs_en,
    input  wire  [7:0]  fcs_byte,
    output logic [31:0] crc_next,
    output logic [31:0] crc
);

    logic [31:0] crc_step;

    // eight bit steps, lsb first
    always_comb begin
        crc_step = crc ^ {24'h0, fcs_byte};
        for (int i = 0; i < 8; i++) begin
            if (crc_step[0])
                crc_step = (crc_step >> 1) ^ icmp_pkg::CRC_POLY_REFL;
            else
                crc_step = crc_step >> 1;
        end
    end

    assign crc_next = crc_step;  // register value with current byte folded in

    // ------------------------------
    // crc register
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            crc <= '1;
        end else if (fcs_clear) begin
            crc <= '1;          // preset for the next frame
        end else if (fcs_en) begin
            crc <= crc_next;
        end
    end

endmodule

`default_nettype wire

/* icmp_frame_tx.sv */
// ------------------------------
// frame sequencer: latches a request, starts both checksums, then
// serializes preamble, headers, payload with padding and FCS on GMII
// ------------------------------
`default_nettype none

module icmp_frame_tx #(
    parameter icmp_pkg::mac_addr_t BOARD_MAC = 48'h00_11_22_33_44_55,
    parameter icmp_pkg::ip_addr_t  BOARD_IP  = {8'd192, 8'd168, 8'd1, 8'd123}
) (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire                   tx_start_en,
    input  wire icmp_pkg::frame_req_t req,
    input  wire  [7:0]            tx_data,
    input  wire  [15:0]           ip_csum,
    input  wire  [15:0]           icmp_csum,
    input  wire                   csum_valid,
    input  wire  [31:0]           crc_next,
    input  wire  [31:0]           crc,
    output logic [9:0][15:0]      ip_words,
    output logic [2:0][15:0]      icmp_words,
    output logic [31:0]           icmp_extra,
    output logic                  calc_start,
    output logic                  fcs_clear,
    output logic                  fcs_en,
    output logic [7:0]            fcs_byte,
    output logic                  tx_req,
    output icmp_pkg::gmii_tx_t    gmii,
    output logic                  tx_done
);

    localparam logic [15:0] HDR_REQ  = 16'(icmp_pkg::IP_ICMP_HDR_LEN - 2);
    localparam logic [15:0] HDR_LAST = 16'(icmp_pkg::IP_ICMP_HDR_LEN - 1);

    icmp_pkg::tx_state_e  state;
    icmp_pkg::frame_req_t req_q;
    logic                 start_d;
    logic                 start_pulse;
    logic [15:0]          cnt;          // byte index inside the current state
    logic [15:0]          ident;
    logic [15:0]          req_cnt;
    logic [15:0]          data_len;     // payload plus padding
    logic [15:0]          ip_csum_q;
    logic [15:0]          icmp_csum_q;
    logic [13:0][7:0]     eth_hdr;
    logic [13:0][15:0]    hdr_words;
    logic [15:0]          hdr_word;
    logic [7:0]           eth_byte;
    logic [7:0]           hdr_byte;

    assign start_pulse = tx_start_en & ~start_d;

    // checksum operands, checksum field zero
    assign ip_words = {{icmp_pkg::IP_VER_IHL, 8'h00},
                       req_q.byte_num + 16'(icmp_pkg::IP_ICMP_HDR_LEN),
                       ident,
                       icmp_pkg::IP_FLAGS_DF,
                       {icmp_pkg::IP_TTL, icmp_pkg::IP_PROTO_ICMP},
                       16'h0000,
                       BOARD_IP,
                       req_q.des_ip};
    assign icmp_words = {{icmp_pkg::ICMP_ECHO_REPLY, 8'h00}, req_q.icmp_id, req_q.icmp_seq};
    assign icmp_extra = req_q.data_sum;

    // ip + icmp headers with both checksums in place, msb word first
    assign hdr_words = {ip_words[9:5], ip_csum_q, ip_words[3:0],
                        icmp_words[2], icmp_csum_q, icmp_words[1:0]};
    assign hdr_word  = hdr_words[4'd13 - cnt[4:1]];
    assign hdr_byte  = cnt[0] ? hdr_word[7:0] : hdr_word[15:8];
    assign eth_hdr   = {req_q.des_mac, BOARD_MAC, icmp_pkg::ETH_TYPE_IPV4};
    assign eth_byte  = eth_hdr[4'd13 - cnt[3:0]];

    assign fcs_byte = gmii.txd;  // crc follows the wire one cycle behind

    // ------------------------------
    // request and checksum capture
    // ------------------------------
    always_ff @(posedge clk) begin
        if (state == icmp_pkg::ST_IDLE && start_pulse) begin
            req_q    <= req;
            data_len <= (req.byte_num < 16'(icmp_pkg::MIN_PAYLOAD)) ?
                        16'(icmp_pkg::MIN_PAYLOAD) : req.byte_num;
        end
        if (state == icmp_pkg::ST_CHECKSUM && csum_valid) begin
            ip_csum_q   <= ip_csum;
            icmp_csum_q <= icmp_csum;
        end
    end

    // ------------------------------
    // sequencer
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= icmp_pkg::ST_IDLE;
            start_d    <= 1'b0;
            cnt        <= '0;
            ident      <= '0;
            req_cnt    <= '0;
            tx_req     <= 1'b0;
            calc_start <= 1'b0;
            fcs_clear  <= 1'b0;
            fcs_en     <= 1'b0;
            gmii       <= '0;
            tx_done    <= 1'b0;
        end else begin
            start_d    <= tx_start_en;
            calc_start <= 1'b0;
            fcs_clear  <= 1'b0;
            fcs_en     <= 1'b0;
            gmii.en    <= 1'b0;
            tx_done    <= gmii.en && state == icmp_pkg::ST_IDLE;  // last fcs byte out

            // payload fetch, exactly byte_num requests
            if (tx_req) begin
                req_cnt <= req_cnt + 16'd1;
                if (req_cnt == req_q.byte_num - 16'd1)
                    tx_req <= 1'b0;
            end

            case (state)
                icmp_pkg::ST_IDLE: begin
                    if (start_pulse) begin
                        state      <= icmp_pkg::ST_CHECKSUM;
                        ident      <= ident + 16'd1;
                        calc_start <= 1'b1;
                        fcs_clear  <= 1'b1;
                    end
                end
                icmp_pkg::ST_CHECKSUM: begin
                    if (csum_valid) begin    // icmp unit finishes together
                        state <= icmp_pkg::ST_PREAMBLE;
                        cnt   <= '0;
                    end
                end
                icmp_pkg::ST_PREAMBLE: begin
                    gmii.en  <= 1'b1;
                    gmii.txd <= (cnt == 16'd7) ? icmp_pkg::SFD_BYTE : icmp_pkg::PREAMBLE_BYTE;
                    cnt      <= cnt + 16'd1;
                    if (cnt == 16'd7) begin
                        state <= icmp_pkg::ST_ETH_HEAD;
                        cnt   <= '0;
                    end
                end
                icmp_pkg::ST_ETH_HEAD: begin
                    gmii.en  <= 1'b1;
                    gmii.txd <= eth_byte;
                    fcs_en   <= 1'b1;
                    cnt      <= cnt + 16'd1;
                    if (cnt == 16'd13) begin
                        state <= icmp_pkg::ST_IP_HEAD;
                        cnt   <= '0;
                    end
                end
                icmp_pkg::ST_IP_HEAD: begin
                    gmii.en  <= 1'b1;
                    gmii.txd <= hdr_byte;
                    fcs_en   <= 1'b1;
                    cnt      <= cnt + 16'd1;
                    if (cnt == HDR_REQ) begin
                        tx_req  <= 1'b1;     // first byte due in the data slot
                        req_cnt <= '0;
                    end
                    if (cnt == HDR_LAST) begin
                        state <= icmp_pkg::ST_DATA;
                        cnt   <= '0;
                    end
                end
                icmp_pkg::ST_DATA: begin
                    gmii.en <= 1'b1;
                    fcs_en  <= 1'b1;
                    if (cnt < req_q.byte_num)
                        gmii.txd <= tx_data; // else hold last byte as pad
                    cnt <= cnt + 16'd1;
                    if (cnt == data_len - 16'd1) begin
                        state <= icmp_pkg::ST_FCS;
                        cnt   <= '0;
                    end
                end
                icmp_pkg::ST_FCS: begin
                    gmii.en <= 1'b1;
                    case (cnt[1:0])
                        2'd0:    gmii.txd <= ~crc_next[7:0];  // last data byte still on wire
                        2'd1:    gmii.txd <= ~crc[15:8];
                        2'd2:    gmii.txd <= ~crc[23:16];
                        default: gmii.txd <= ~crc[31:24];
                    endcase
                    cnt <= cnt + 16'd1;
                    if (cnt == 16'd3) begin
                        state <= icmp_pkg::ST_IDLE;
                        cnt   <= '0;
                    end
                end
                default: state <= icmp_pkg::ST_IDLE;
            endcase
        end
    end

    // ------------------------------
    // checks
    // ------------------------------
    a_req_window: assert property (@(posedge clk) disable iff (!rst_n)
        tx_req |-> (state == icmp_pkg::ST_IP_HEAD && cnt == HDR_LAST) ||
                   state == icmp_pkg::ST_DATA);

    a_en_end: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(gmii.en) |-> $past(state, 2) == icmp_pkg::ST_FCS);

endmodule

`default_nettype wire

/* icmp_tx_top.sv */
// ------------------------------
// ICMP echo-reply transmitter top, board addresses set here
// connects the sequencer to its two checksum units and the FCS unit
// ------------------------------
`default_nettype none

module icmp_tx_top #(
    parameter icmp_pkg::mac_addr_t BOARD_MAC = 48'h00_11_22_33_44_55,
    parameter icmp_pkg::ip_addr_t  BOARD_IP  = {8'd192, 8'd168, 8'd1, 8'd123}
) (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire                       tx_start_en,
    input  wire icmp_pkg::frame_req_t req,
    input  wire  [7:0]                tx_data,
    output logic                      tx_req,
    output icmp_pkg::gmii_tx_t        gmii,
    output logic                      tx_done
);

    logic [9:0][15:0] ip_words;
    logic [2:0][15:0] icmp_words;
    logic [31:0]      icmp_extra;
    logic             calc_start;
    logic [15:0]      ip_csum;
    logic [15:0]      icmp_csum;
    logic             ip_csum_valid;
    logic             fcs_clear;
    logic             fcs_en;
    logic [7:0]       fcs_byte;
    logic [31:0]      crc_next;
    logic [31:0]      crc;

    icmp_frame_tx #(
        .BOARD_MAC (BOARD_MAC),
        .BOARD_IP  (BOARD_IP)
    ) u_frame_tx (
        .clk         (clk),
        .rst_n       (rst_n),
        .tx_start_en (tx_start_en),
        .req         (req),
        .tx_data     (tx_data),
        .ip_csum     (ip_csum),
        .icmp_csum   (icmp_csum),
        .csum_valid  (ip_csum_valid),
        .crc_next    (crc_next),
        .crc         (crc),
        .ip_words    (ip_words),
        .icmp_words  (icmp_words),
        .icmp_extra  (icmp_extra),
        .calc_start  (calc_start),
        .fcs_clear   (fcs_clear),
        .fcs_en      (fcs_en),
        .fcs_byte    (fcs_byte),
        .tx_req      (tx_req),
        .gmii        (gmii),
        .tx_done     (tx_done)
    );

    // ip header checksum, no extra addend
    inet_checksum #(.N_WORDS(10)) u_ip_csum (
        .clk        (clk),
        .rst_n      (rst_n),
        .calc_start (calc_start),
        .words      (ip_words),
        .extra      (32'd0),
        .csum       (ip_csum),
        .csum_valid (ip_csum_valid)
    );

    // icmp header plus payload sum, same latency as the ip unit
    inet_checksum #(.N_WORDS(3)) u_icmp_csum (
        .clk        (clk),
        .rst_n      (rst_n),
        .calc_start (calc_start),
        .words      (icmp_words),
        .extra      (icmp_extra),
        .csum       (icmp_csum),
        .csum_valid ()
    );

    eth_fcs u_fcs (
        .clk       (clk),
        .rst_n     (rst_n),
        .fcs_clear (fcs_clear),
        .fcs_en    (fcs_en),
        .fcs_byte  (fcs_byte),
        .crc_next  (crc_next),
        .crc       (crc)
    );

endmodule

`default_nettype wire

/* tb_icmp_ref.svh */
// ------------------------------
// reference model for the ICMP echo-reply frame
// included inside the testbench module body
// ------------------------------
`ifndef TB_ICMP_REF_SVH
`define TB_ICMP_REF_SVH

typedef logic [7:0] byte_q_t[$];

// bytes on gmii for n payload bytes, preamble through FCS
function automatic int frame_len(input int n);
    return 8 + 14 + 28 + ((n < 18) ? 18 : n) + 4;
endfunction

// end-around carry until it settles, then complement
function automatic logic [15:0] fold_invert(input logic [31:0] s);
    logic [31:0] t;
    t = s;
    while (t[31:16] != 16'h0)
        t = 32'(t[31:16]) + 32'(t[15:0]);
    return ~t[15:0];
endfunction

// reflected crc-32, one data bit at a time
function automatic logic [31:0] crc_add_byte(input logic [31:0] c, input logic [7:0] b);
    logic [31:0] r;
    r = c;
    for (int i = 0; i < 8; i++) begin
        if (r[0] ^ b[i])
            r = (r >> 1) ^ 32'hedb88320;
        else
            r = r >> 1;
    end
    return r;
endfunction

function automatic byte_q_t ref_frame(input icmp_pkg::frame_req_t r, input byte_q_t pay,
                                      input logic [15:0] ident,
                                      input icmp_pkg::mac_addr_t mac,
                                      input icmp_pkg::ip_addr_t ip);
    byte_q_t     f;
    logic [15:0] hw [14];   // ip header, then icmp header
    logic [31:0] s;
    logic [31:0] crc;
    int          n;
    n = pay.size();
    hw[0]  = 16'h4500;
    hw[1]  = 16'(n + 28);   // padding not counted
    hw[2]  = ident;
    hw[3]  = 16'h4000;      // don't fragment
    hw[4]  = 16'h8001;      // ttl 128, icmp
    hw[5]  = 16'h0000;
    hw[6]  = ip[31:16];
    hw[7]  = ip[15:0];
    hw[8]  = r.des_ip[31:16];
    hw[9]  = r.des_ip[15:0];
    hw[10] = 16'h0000;      // echo reply, code 0
    hw[11] = 16'h0000;
    hw[12] = r.icmp_id;
    hw[13] = r.icmp_seq;
    s = 32'd0;
    for (int i = 0; i < 10; i++)
        s = s + 32'(hw[i]);
    hw[5] = fold_invert(s);
    // icmp checksum covers the payload, odd tail byte in the high half
    s = 32'(hw[10]) + 32'(hw[12]) + 32'(hw[13]);
    for (int i = 0; i < n; i++)
        s = s + (i[0] ? 32'(pay[i]) : {16'h0, pay[i], 8'h00});
    hw[11] = fold_invert(s);

    for (int i = 0; i < 7; i++)
        f.push_back(8'h55);
    f.push_back(8'hd5);
    for (int i = 5; i >= 0; i--)
        f.push_back(r.des_mac[i*8 +: 8]);
    for (int i = 5; i >= 0; i--)
        f.push_back(mac[i*8 +: 8]);
    f.push_back(8'h08);
    f.push_back(8'h00);
    for (int i = 0; i < 14; i++) begin
        f.push_back(hw[i][15:8]);
        f.push_back(hw[i][7:0]);
    end
    for (int i = 0; i < n; i++)
        f.push_back(pay[i]);
    for (int i = n; i < 18; i++)
        f.push_back(pay[n - 1]);    // pad by repeating the last byte
    crc = 32'hffffffff;
    for (int i = 8; i < f.size(); i++)
        crc = crc_add_byte(crc, f[i]);
    crc = ~crc;
    for (int i = 0; i < 4; i++)
        f.push_back(crc[i*8 +: 8]);  // least significant byte first
    return f;
endfunction

`endif

/* tb_icmp_tx.sv */
// ------------------------------
// testbench for the ICMP echo-reply transmitter
// drives frame requests, models the payload source, checks each
// frame on GMII against the reference model
// ------------------------------
`default_nettype none

module tb_icmp_tx;

    localparam icmp_pkg::mac_addr_t BOARD_MAC = 48'h02_00_5e_10_20_30;
    localparam icmp_pkg::ip_addr_t  BOARD_IP  = {8'd10, 8'd0, 8'd0, 8'd7};
    localparam int N_FRAMES = 6;
    localparam int PAY_LEN [N_FRAMES] = '{64, 5, 18, 33, 46, 40};

    `include "tb_icmp_ref.svh"

    logic                 clk;
    logic                 rst_n;
    logic                 tx_start_en;
    icmp_pkg::frame_req_t req;
    logic [7:0]           tx_data;
    logic                 tx_req;
    icmp_pkg::gmii_tx_t   gmii;
    logic                 tx_done;

    byte_q_t     src_q;         // payload bytes still to be fetched
    byte_q_t     exp_q;
    byte_q_t     act_q;
    int          exp_len_q[$];
    int          exp_req_q[$];
    int          act_len_q[$];
    int          act_req_q[$];
    int          cur_len = 0;
    int          req_seen = 0;  // tx_req cycles in the current frame
    int          frames_done = 0;
    logic [15:0] ident_next;
    bit          started = 1'b0;

    icmp_tx_top #(.BOARD_MAC(BOARD_MAC), .BOARD_IP(BOARD_IP)) UUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .tx_start_en (tx_start_en),
        .req         (req),
        .tx_data     (tx_data),
        .tx_req      (tx_req),
        .gmii        (gmii),
        .tx_done     (tx_done)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ------------------------------
    // error handling and compare tasks
    // ------------------------------
    task automatic abort_run(input string why);
        $display("%s", why);
        $display("*** FAILED ***");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
        if (act !== exp)
            abort_run($sformatf("MISMATCH t=%0t %s expected %02h actual %02h",
                                $time, name, exp, act));
    endtask

    task automatic check_len(input string name, input int exp, input int act);
        if (act != exp)
            abort_run($sformatf("MISMATCH t=%0t %s expected %0d actual %0d",
                                $time, name, exp, act));
    endtask

    task automatic check_done(input string name, input logic exp, input logic act);
        if (act !== exp)
            abort_run($sformatf("MISMATCH t=%0t %s expected %b actual %b",
                                $time, name, exp, act));
    endtask

    task automatic compare_frame();
        int act_len;
        int act_req;
        if (exp_len_q.size() == 0)
            abort_run("a frame appeared on gmii without a start");
        act_len = act_len_q.pop_front();
        act_req = act_req_q.pop_front();
        check_len("frame length", exp_len_q.pop_front(), act_len);
        check_len("tx_req cycles", exp_req_q.pop_front(), act_req);
        for (int i = 0; i < act_len; i++)
            check_byte($sformatf("gmii.txd byte %0d", i), exp_q.pop_front(), act_q.pop_front());
        frames_done++;
    endtask

    // ------------------------------
    // payload source, monitor, compare
    // ------------------------------
    always @(posedge clk) begin
        if (tx_req) begin
            if (src_q.size() == 0)
                abort_run("tx_req asked for a payload byte beyond the payload");
            else
                tx_data <= src_q.pop_front();  // byte due one cycle later
        end
    end

    always @(posedge clk) begin
        if (rst_n) begin
            if (tx_req)
                req_seen++;
            if (!started) begin
                check_done("gmii.en", 1'b0, gmii.en);
                check_done("tx_req", 1'b0, tx_req);
            end
            if (gmii.en) begin
                act_q.push_back(gmii.txd);
                cur_len++;
                check_done("tx_done", 1'b0, tx_done);
            end else if (cur_len != 0) begin
                check_done("tx_done", 1'b1, tx_done);  // first cycle after the frame
                act_len_q.push_back(cur_len);
                act_req_q.push_back(req_seen);
                cur_len = 0;
                req_seen = 0;
            end else begin
                check_done("tx_done", 1'b0, tx_done);
            end
        end
    end

    initial begin
        forever begin
            @(posedge clk);
            if (act_len_q.size() != 0)
                compare_frame();
        end
    end

    // ------------------------------
    // stimulus
    // ------------------------------
    task automatic apply_reset();
        rst_n <= 1'b0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        ident_next = 16'd1;
    endtask

    task automatic send_frame(input int n, input bit poke_mid);
        icmp_pkg::frame_req_t r;
        byte_q_t              pay;
        byte_q_t              exp;
        logic [31:0]          sum;
        int                   target;
        sum = 32'd0;
        for (int i = 0; i < n; i++)
            pay.push_back(8'($urandom));
        for (int i = 0; i < n; i += 2)
            sum = sum + 32'({pay[i], (i + 1 < n) ? pay[i + 1] : 8'h00});
        r.des_mac  = {16'h0a1b, 32'($urandom)};
        r.des_ip   = 32'($urandom);
        r.icmp_id  = 16'($urandom);
        r.icmp_seq = 16'($urandom);
        r.byte_num = 16'(n);
        r.data_sum = sum;
        exp = ref_frame(r, pay, ident_next, BOARD_MAC, BOARD_IP);
        foreach (exp[i])
            exp_q.push_back(exp[i]);
        exp_len_q.push_back(exp.size());
        exp_req_q.push_back(n);
        foreach (pay[i])
            src_q.push_back(pay[i]);
        ident_next++;
        target  = frames_done + 1;
        started = 1'b1;
        @(posedge clk);
        tx_start_en <= 1'b1;
        req         <= r;
        @(posedge clk);
        tx_start_en <= 1'b0;
        req         <= '0;
        if (poke_mid) begin
            while (!gmii.en)
                @(posedge clk);
            repeat (10) @(posedge clk);
            tx_start_en <= 1'b1;   // second edge while the frame is on the wire
            @(posedge clk);
            tx_start_en <= 1'b0;
        end
        while (frames_done < target)
            @(posedge clk);
    endtask

    initial begin
        void'($urandom(32'hf82));
        tx_start_en <= 1'b0;
        req         <= '0;
        tx_data     <= '0;
        apply_reset();
        repeat (10) @(posedge clk);    // quiet until the first start
        send_frame(PAY_LEN[0], 1'b0);
        send_frame(PAY_LEN[1], 1'b0);  // padded
        @(posedge clk);
        apply_reset();                 // identification restarts at 1
        send_frame(PAY_LEN[2], 1'b0);
        send_frame(PAY_LEN[3], 1'b0);
        send_frame(PAY_LEN[4], 1'b0);
        send_frame(PAY_LEN[5], 1'b1);
        repeat (30) @(posedge clk);
        check_len("bytes of an unexpected frame", 0, cur_len);
        $display("*** PASSED ***");
        $finish;
    end

    // watchdog sized from the frame lengths
    initial begin
        int limit;
        limit = 0;
        for (int i = 0; i < N_FRAMES; i++)
            limit += frame_len(PAY_LEN[i]) + 20;
        repeat (2 * limit) @(posedge clk);
        abort_run($sformatf("timeout: run still going after %0d cycles", 2 * limit));
    end

endmodule

`default_nettype wire

/* flist.f */
+incdir+.
icmp_pkg.sv
inet_checksum.sv
eth_fcs.sv
icmp_frame_tx.sv
icmp_tx_top.sv
tb_icmp_tx.sv

/* run.sh */
#!/bin/sh
# build and run the ICMP transmitter testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f flist.f \
    --top-module tb_icmp_tx -o tb_icmp_tx
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/tb_icmp_tx > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q '^\*\*\* PASSED \*\*\*$' "$LOG"; then
    exit 0
fi
exit 1
